/* all.f */
hw/irq_pkg.sv
hw/irq_source_edge.sv
hw/irq_flag_latch.sv
hw/irq_request_gate.sv
hw/irq_register_file.sv
hw/irq_subsystem_top.sv
dv/tb_irq_subsystem.sv

/* Makefile */
TOP = tb_irq_subsystem
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f all.f

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/tb_irq_subsystem.sv */
// Needs a simulator with timing support; sources are driven on the clock and the run stops at the first mismatch.
module tb_irq_subsystem
    import irq_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int reset_cycles   = 10;
    localparam int rand_ops       = 250;
    localparam int directed_txns  = num_irq_sources * 3 + 40; // Bus transactions in tests 1 to 5.
    localparam int cycles_per_txn = 20;                       // Room for rsp_ready stalls.
    localparam int timeout_cycles =
        reset_cycles + (directed_txns + rand_ops) * cycles_per_txn + 500;

    typedef struct packed {
        irq_sources_t flags;
        logic         nirq;
    } model_state_t;

    logic         clock;
    logic         reset;
    irq_sources_t sources;
    logic         req_valid;
    logic         req_ready;
    reg_req_t     req;
    logic         rsp_valid;
    logic         rsp_ready;
    reg_rsp_t     rsp;
    logic [4:0]   cpu_mode;
    logic         nirq;

    // Reference model state.
    irq_sources_t m_prev;
    irq_sources_t m_edges;
    irq_sources_t m_ack;
    irq_sources_t m_ie;
    logic         m_ime;
    logic         m_rsp_pending;
    model_state_t m_state;
    logic [15:0]  exp_rdata [$]; // Expected response data, oldest first.

    string test_name = "reset";
    int    seed = 94194;
    int    cycle_count = 0;

    irq_subsystem_top UUT (
        .clock     (clock),
        .reset     (reset),
        .sources   (sources),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .cpu_mode  (cpu_mode),
        .nirq      (nirq)
    );

    always #50 clock = ~clock; // 100 ns period.

    // Next flags and nIRQ from the current model state.
    function automatic model_state_t ref_step(irq_sources_t flags, irq_sources_t edges_seen,
                                              irq_sources_t ack_mask, irq_sources_t ie_val,
                                              logic ime_val, logic [4:0] mode);
        model_state_t next;
        next.flags = irq_sources_t'((flags | edges_seen) & ~ack_mask); // Clear wins.
        next.nirq  = !(ime_val && (mode == irq_mode) && ((flags & ie_val) != '0));
        return next;
    endfunction

    task automatic expect_value(input string what, input logic [15:0] expected,
                                input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    // One request and its response; stall draws rsp_ready at random each cycle.
    task automatic bus_access(input logic write, input logic [1:0] addr, input logic [15:0] wdata,
                              input logic stall, output logic [15:0] rdata);
        logic delivered;
        req_valid <= 1'b1;
        req       <= '{write: write, addr: addr, wdata: wdata};
        do begin
            @(posedge clock);
        end while (!req_ready);
        req_valid <= 1'b0;
        delivered = 1'b0;
        while (!delivered) begin
            rsp_ready <= stall ? 1'($random(seed)) : 1'b1;
            @(posedge clock);
            delivered = rsp_valid && rsp_ready;
        end
        rdata = rsp.rdata;
        rsp_ready <= 1'b1;
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [15:0] data, input logic stall);
        logic [15:0] unused_rdata;
        bus_access(1'b1, addr, data, stall, unused_rdata);
    endtask

    task automatic read_reg(input logic [1:0] addr, input logic stall, output logic [15:0] data);
        bus_access(1'b0, addr, 16'h0000, stall, data);
    endtask

    task automatic check_nirq(input logic expected);
        repeat (2) @(posedge clock); // Let the new condition reach the registered output.
        expect_value("nirq", 16'(expected), 16'(nirq));
    endtask

    // Steps the model on every edge and compares the DUT against it.
    always @(posedge clock) begin : model_and_check
        model_state_t next_state;
        logic         accept;
        if (reset) begin
            m_prev        <= '0;
            m_edges       <= '0;
            m_ack         <= '0;
            m_ie          <= '0;
            m_ime         <= 1'b0;
            m_rsp_pending <= 1'b0;
            m_state       <= '{flags: '0, nirq: 1'b1};
        end else begin
            expect_value("nirq", 16'(m_state.nirq), 16'(nirq));
            expect_value("rsp_valid", 16'(m_rsp_pending), 16'(rsp_valid));
            expect_value("req_ready", 16'(!m_rsp_pending), 16'(req_ready));
            if (m_rsp_pending && rsp_ready) begin
                expect_value("rdata", exp_rdata.pop_front(), rsp.rdata);
            end
            accept = req_valid && !m_rsp_pending;
            if (accept && !req.write) begin
                case (req.addr)
                    addr_ie:  exp_rdata.push_back({2'b00, m_ie});
                    addr_if:  exp_rdata.push_back({2'b00, m_state.flags}); // Flags at accept.
                    addr_ime: exp_rdata.push_back({15'h0000, m_ime});
                    default:  exp_rdata.push_back(16'h0000);
                endcase
            end else if (accept) begin
                exp_rdata.push_back(16'h0000); // Writes answer zero.
            end
            next_state = ref_step(m_state.flags, m_edges, m_ack, m_ie, m_ime, cpu_mode);
            m_state <= next_state;
            m_edges <= irq_sources_t'(sources & ~m_prev);
            m_prev  <= sources;
            m_ack   <= '0;
            if (accept && req.write && req.addr == addr_if) begin
                m_ack <= irq_sources_t'(req.wdata[num_irq_sources-1:0]);
            end
            if (accept && req.write && req.addr == addr_ie) begin
                m_ie <= irq_sources_t'(req.wdata[num_irq_sources-1:0]);
            end
            if (accept && req.write && req.addr == addr_ime) begin
                m_ime <= req.wdata[0];
            end
            if (accept) begin
                m_rsp_pending <= 1'b1;
            end else if (rsp_ready) begin
                m_rsp_pending <= 1'b0;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    end

    initial begin
        int          r;
        logic [15:0] rd;
        clock     = 1'b0;
        reset     = 1'b1;
        sources   = '0;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b1;
        cpu_mode  = irq_mode;
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);

        read_reg(addr_if, 1'b0, rd);
        expect_value("IF", 16'h0000, rd);
        read_reg(addr_ie, 1'b0, rd);
        expect_value("IE", 16'h0000, rd);
        read_reg(addr_ime, 1'b0, rd);
        expect_value("IME", 16'h0000, rd);
        expect_value("nirq after reset", 16'h0001, 16'(nirq));

        test_name = "per_source";
        for (int i = 0; i < num_irq_sources; i++) begin
            sources <= irq_sources_t'(14'(1) << i);
            repeat (3) @(posedge clock);
            read_reg(addr_if, 1'b0, rd);
            expect_value("IF after raise", 16'(1) << i, rd);
            write_reg(addr_if, 16'(1) << i, 1'b0);
            repeat (3) @(posedge clock); // Level still held.
            read_reg(addr_if, 1'b0, rd);
            expect_value("IF after clear", 16'h0000, rd);
            sources <= '0;
            @(posedge clock);
        end

        test_name = "if_clear";
        sources <= irq_sources_t'(14'h3fff);
        @(posedge clock);
        sources <= '0;
        repeat (3) @(posedge clock);
        read_reg(addr_if, 1'b0, rd);
        expect_value("IF all set", 16'h3fff, rd);
        write_reg(addr_if, 16'h0f0f, 1'b0);
        read_reg(addr_if, 1'b0, rd);
        expect_value("IF partial clear", 16'h30f0, rd);
        sources <= irq_sources_t'(14'h0001); // Edge meets the ack in one cycle.
        write_reg(addr_if, 16'h0001, 1'b0);
        read_reg(addr_if, 1'b0, rd);
        expect_value("IF clear beats set", 16'h30f0, rd);
        sources <= '0;
        write_reg(addr_if, 16'hffff, 1'b0);
        read_reg(addr_if, 1'b0, rd);
        expect_value("IF cleared", 16'h0000, rd);

        test_name = "gating";
        sources <= irq_sources_t'(14'h0010); // Timer1.
        @(posedge clock);
        sources <= '0;
        check_nirq(1'b1);
        write_reg(addr_ie, 16'h0010, 1'b0);
        check_nirq(1'b1);
        write_reg(addr_ime, 16'h0001, 1'b0);
        check_nirq(1'b0);
        cpu_mode <= 5'b11111;
        check_nirq(1'b1);
        cpu_mode <= irq_mode;
        check_nirq(1'b0);
        write_reg(addr_ie, 16'h0020, 1'b0);
        check_nirq(1'b1);
        write_reg(addr_ie, 16'h0010, 1'b0);
        check_nirq(1'b0);
        write_reg(addr_ime, 16'h0000, 1'b0);
        check_nirq(1'b1);
        write_reg(addr_ime, 16'h0001, 1'b0);
        check_nirq(1'b0);
        write_reg(addr_if, 16'h0010, 1'b0);
        check_nirq(1'b1);

        test_name = "backpressure";
        write_reg(addr_ie, 16'h2a55, 1'b0);
        rsp_ready <= 1'b0;
        req_valid <= 1'b1;
        req       <= '{write: 1'b0, addr: addr_ie, wdata: 16'h0000};
        @(posedge clock);
        req <= '{write: 1'b0, addr: addr_ime, wdata: 16'h0000}; // Queued behind the first.
        repeat (6) begin
            @(posedge clock);
            expect_value("held rsp_valid", 16'h0001, 16'(rsp_valid));
            expect_value("held req_ready", 16'h0000, 16'(req_ready));
            expect_value("held rdata", 16'h2a55, rsp.rdata);
        end
        rsp_ready <= 1'b1;
        do begin
            @(posedge clock);
        end while (!req_ready);
        req_valid <= 1'b0;
        do begin
            @(posedge clock);
        end while (!rsp_valid);

        test_name = "random";
        for (int n = 0; n < rand_ops; n++) begin
            r = $random(seed);
            case (r[2:0])
                3'd0, 3'd1: begin
                    sources <= irq_sources_t'(sources ^ 14'(r >> 8));
                    @(posedge clock);
                end
                3'd2: write_reg(addr_ie, 16'(r >> 8), r[3]);
                3'd3: write_reg(addr_ime, 16'(r >> 8), r[3]);
                3'd4: write_reg(addr_if, 16'(r >> 8), r[3]);
                3'd5: read_reg(2'(r >> 8), r[3], rd);
                3'd6: begin
                    cpu_mode <= r[8] ? irq_mode : 5'(r >> 9);
                    @(posedge clock);
                end
                default: repeat (r[9:8]) @(posedge clock);
            endcase
        end

        test_name = "drain";
        repeat (4) @(posedge clock);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule : tb_irq_subsystem

/* hw/irq_subsystem_top.sv */
// Sources are synchronous levels; nirq lags a new source edge by three clocks.
module irq_subsystem_top
    import irq_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  irq_sources_t sources,
    input  logic         req_valid,
    output logic         req_ready,
    input  reg_req_t     req,
    output logic         rsp_valid,
    input  logic         rsp_ready,
    output reg_rsp_t     rsp,
    input  logic [4:0]   cpu_mode,
    output logic         nirq
);

    irq_sources_t edges;
    irq_sources_t flags;
    irq_sources_t ack;
    irq_sources_t ie;
    logic         ime;

    // Level to pulse.
    irq_source_edge u_source_edge (
        .clock   (clock),
        .reset   (reset),
        .sources (sources),
        .edges   (edges)
    );

    // Sticky pending flags.
    irq_flag_latch u_flag_latch (
        .clock (clock),
        .reset (reset),
        .edges (edges),
        .ack   (ack),
        .flags (flags)
    );

    irq_request_gate u_request_gate (
        .clock    (clock),
        .reset    (reset),
        .flags    (flags),
        .ie       (ie),
        .ime      (ime),
        .cpu_mode (cpu_mode),
        .nirq     (nirq)
    );

    // CPU-facing registers.
    irq_register_file u_register_file (
        .clock     (clock),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .flags     (flags),
        .ie        (ie),
        .ime       (ime),
        .ack       (ack)
    );

endmodule : irq_subsystem_top

/* hw/irq_register_file.sv */
// One transaction in flight at a time; unmapped addresses read zero and ignore writes.
module irq_register_file
    import irq_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         req_valid,
    output logic         req_ready,
    input  reg_req_t     req,
    output logic         rsp_valid,
    input  logic         rsp_ready,
    output reg_rsp_t     rsp,
    input  irq_sources_t flags, // For IF readback.
    output irq_sources_t ie,    // Enable mask.
    output logic         ime,   // Master enable.
    output irq_sources_t ack    // One-cycle clear mask.
);

    localparam int pad_width = 16 - num_irq_sources;

    logic        accept;
    logic        wr_ie;
    logic        wr_if;
    logic        wr_ime;
    logic [15:0] read_data;

    // Hold off new requests until the pending response has gone out.
    assign req_ready = ~rsp_valid;
    assign accept    = req_valid && req_ready;

    // Write decode.
    assign wr_ie  = accept && req.write && (req.addr == addr_ie);
    assign wr_if  = accept && req.write && (req.addr == addr_if);
    assign wr_ime = accept && req.write && (req.addr == addr_ime);

    // Read mux, sampled at the accepting edge.
    always_comb begin
        read_data = 16'h0000;
        if (!req.write) begin
            case (req.addr)
                addr_ie:  read_data = {{pad_width{1'b0}}, ie};
                addr_if:  read_data = {{pad_width{1'b0}}, flags};
                addr_ime: read_data = {15'h0000, ime};
                default:  read_data = 16'h0000;
            endcase
        end
    end

    // IE and IME take the written value on the accepting edge.
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            ie  <= '0;
            ime <= 1'b0;
        end else begin
            if (wr_ie) begin
                ie <= irq_sources_t'(req.wdata[num_irq_sources-1:0]); // Upper bits dropped.
            end
            if (wr_ime) begin
                ime <= req.wdata[0];
            end
        end
    end

    // Writing ones to IF clears those flags.
    // The mask lives for a single cycle only.
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            ack <= '0;
        end else if (wr_if) begin
            ack <= irq_sources_t'(req.wdata[num_irq_sources-1:0]);
        end else begin
            ack <= '0;
        end
    end

    // Response handshake.
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0; // Delivered.
        end
    end

    // Payload is loaded only on accept, so it stays put under back-pressure.
    always_ff @(posedge clock) begin
        if (accept) begin
            rsp.rdata <= read_data; // Zero for writes.
        end
    end

endmodule : irq_register_file

/* hw/irq_request_gate.sv */
// nirq is active low and registered; it only asserts while the CPU reports IRQ mode.
module irq_request_gate
    import irq_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  irq_sources_t flags,    // Pending flags.
    input  irq_sources_t ie,       // Enable mask.
    input  logic         ime,      // Master enable.
    input  logic [4:0]   cpu_mode, // Current CPU mode field.
    output logic         nirq      // Active-low request to the CPU.
);

    logic any_enabled;
    logic request;

    assign any_enabled = |(flags & ie); // At least one pending and enabled.

    // All three conditions must hold together.
    assign request = any_enabled && ime && (cpu_mode == irq_mode);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            nirq <= 1'b1; // Deasserted.
        end else begin
            nirq <= ~request;
        end
    end

endmodule : irq_request_gate

/* hw/irq_flag_latch.sv */
// Pending flags are sticky until acked; an ack in the same cycle as an edge leaves the flag clear.
module irq_flag_latch
    import irq_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  irq_sources_t edges, // Set pulses from the edge stage.
    input  irq_sources_t ack,   // Clear mask from an IF write.
    output irq_sources_t flags  // Pending interrupt flags.
);

    irq_sources_t flags_set;
    irq_sources_t flags_next;

    // New events merge into whatever is already pending.
    assign flags_set = irq_sources_t'(flags | edges);

    // Clear takes priority over set.
    assign flags_next = irq_sources_t'(flags_set & ~ack);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            flags <= '0; // Nothing pending out of reset.
        end else begin
            flags <= flags_next;
        end
    end

endmodule : irq_flag_latch

/* hw/irq_source_edge.sv */
// Sources must be synchronous to clock; only a low-to-high transition raises a pulse.
module irq_source_edge
    import irq_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  irq_sources_t sources, // Raw event levels.
    output irq_sources_t edges    // One-cycle rising-edge pulses.
);

    irq_sources_t sources_q; // Last sampled level of every source.
    irq_sources_t rising;

    // A bit rises when it is high now and was low at the previous edge.
    assign rising = irq_sources_t'(sources & ~sources_q);

    // Keep the previous sample.
    // Starting from zero means a source already high
    // when reset drops counts as a fresh event.
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            sources_q <= '0;
        end else begin
            sources_q <= sources;
        end
    end

    // Register the pulses so the stage boundary is clean.
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            edges <= '0;
        end else begin
            edges <= rising; // High for exactly one cycle.
        end
    end

endmodule : irq_source_edge

/* hw/irq_pkg.sv */
// Shared types and constants; the source set is fixed at fourteen and IE/IF bits above 13 read zero.
package irq_pkg;

    localparam int num_irq_sources = 14; // Fixed by the register map.

    // Word addresses on the CPU register bus. Address 3 is unmapped and reads zero.
    localparam logic [1:0] addr_ie  = 2'd0;
    localparam logic [1:0] addr_if  = 2'd1;
    localparam logic [1:0] addr_ime = 2'd2;

    localparam logic [4:0] irq_mode = 5'b10010; // CPSR mode field for IRQ.

    // One bit per source. Fields are listed MSB first, so vblank lands on bit 0
    // and game_pak on bit 13, matching the IE and IF bit layout.
    typedef struct packed {
        logic game_pak;     // Bit 13.
        logic keypad;       // Bit 12.
        logic dma3;
        logic dma2;
        logic dma1;
        logic dma0;         // Bit 8.
        logic serial;       // Bit 7.
        logic timer3;
        logic timer2;
        logic timer1;
        logic timer0;       // Bit 3.
        logic vcount_match; // Bit 2.
        logic hblank;       // Bit 1.
        logic vblank;       // Bit 0.
    } irq_sources_t;

    // A single register access from the CPU side.
    typedef struct packed {
        logic        write; // High for a write, low for a read.
        logic [1:0]  addr;  // Word address.
        logic [15:0] wdata; // Ignored on reads.
    } reg_req_t;

    // Response payload. Writes return zero.
    typedef struct packed {
        logic [15:0] rdata;
    } reg_rsp_t;

endpackage : irq_pkg
